/* common/cpu_types_pkg.sv */
/*
 * base data types and ALU operation bit names shared by the execute end
 */
`default_nettype none

package cpu_types_pkg;

	typedef logic [31:0] word_t;
	// register 0 reads as zero
	typedef logic [4:0] reg_addr_t;

	////////////////////////////////////////////////////////////////////////
	// one-hot ALU operation, bit index names

	localparam int ALU_OPS = 19;
	typedef logic [ALU_OPS-1:0] alu_op_t;

	localparam int ALU_ADD   = 0;
	localparam int ALU_SUB   = 1;
	localparam int ALU_SLT   = 2;
	localparam int ALU_SLTU  = 3;
	localparam int ALU_AND   = 4;
	localparam int ALU_NOR   = 5;
	localparam int ALU_OR    = 6;
	localparam int ALU_XOR   = 7;
	localparam int ALU_ANDN  = 8;
	localparam int ALU_ORN   = 9;
	localparam int ALU_SLL   = 10;
	localparam int ALU_SRL   = 11;
	localparam int ALU_SRA   = 12;
	localparam int ALU_LUI   = 13;
	localparam int ALU_MUL   = 14;
	localparam int ALU_MULH  = 15;
	localparam int ALU_MULHU = 16;
	localparam int ALU_SRC2  = 17;
	localparam int ALU_SRC1  = 18;

	////////////////////////////////////////////////////////////////////////
	// stage at which a result becomes ready, one bit per stage

	typedef logic [2:0] ready_stage_t;

	localparam int RS_EXE  = 0;
	localparam int RS_PMEM = 1;
	// loads, data only after the RAM returns
	localparam int RS_WB   = 2;

	// data RAM access width
	typedef logic [1:0] mem_size_t;

	localparam mem_size_t MEM_BYTE = 2'd0;
	localparam mem_size_t MEM_HALF = 2'd1;
	localparam mem_size_t MEM_WORD = 2'd2;

endpackage

`default_nettype wire

/* common/pipe_bus_pkg.sv */
/*
 * stage-to-stage and bypass bus layouts for the execute end of the pipeline
 */
`default_nettype none

package pipe_bus_pkg;

	// decoded instruction as it leaves decode
	typedef struct packed {
		cpu_types_pkg::word_t        pc;
		cpu_types_pkg::word_t        src1;
		cpu_types_pkg::word_t        src2;
		cpu_types_pkg::alu_op_t      op;
		logic                        mem_en;
		logic                        mem_we;
		cpu_types_pkg::mem_size_t    mem_size;
		logic                        mem_signed;
		cpu_types_pkg::word_t        mem_wdata;
		logic                        rf_we;
		logic                        rf_from_mem;
		cpu_types_pkg::reg_addr_t    rf_waddr;
		cpu_types_pkg::ready_stage_t ready_stage;
	} id_to_exe_t;

	// operands and op replaced by the ALU result
	typedef struct packed {
		cpu_types_pkg::word_t        pc;
		cpu_types_pkg::word_t        result;
		logic                        mem_en;
		logic                        mem_we;
		cpu_types_pkg::mem_size_t    mem_size;
		logic                        mem_signed;
		cpu_types_pkg::word_t        mem_wdata;
		logic                        rf_we;
		logic                        rf_from_mem;
		cpu_types_pkg::reg_addr_t    rf_waddr;
		cpu_types_pkg::ready_stage_t ready_stage;
	} exe_to_pmem_t;

	// result carries the full address for loads and stores
	typedef struct packed {
		cpu_types_pkg::word_t        pc;
		cpu_types_pkg::word_t        result;
		logic [1:0]                  byte_offset;
		cpu_types_pkg::mem_size_t    mem_size;
		logic                        mem_signed;
		logic                        rf_we;
		logic                        rf_from_mem;
		cpu_types_pkg::reg_addr_t    rf_waddr;
	} pmem_to_wb_t;

	// producer info each stage offers to the bypass unit
	typedef struct packed {
		logic                        valid;
		logic                        rf_we;
		logic                        result_ready;
		cpu_types_pkg::reg_addr_t    rf_waddr;
		cpu_types_pkg::word_t        result;
	} stage_bypass_t;

endpackage

`default_nettype wire

/* exe/alu.sv */
/*
 * combinational 32-bit ALU driven by a one-hot op vector; the selected
 * results are ORed, so an all-zero op yields zero
 */
`default_nettype none
`timescale 1ns/1ps

module alu (
	input  wire cpu_types_pkg::alu_op_t op,
	input  wire cpu_types_pkg::word_t   src1,
	input  wire cpu_types_pkg::word_t   src2,
	output cpu_types_pkg::word_t        result
);
	import cpu_types_pkg::*;

	word_t              add_result;
	word_t              sub_result;
	word_t              slt_result;
	word_t              sltu_result;
	word_t              sll_result;
	word_t              srl_result;
	word_t              sra_result;
	logic [4:0]         shamt;
	logic signed [63:0] mul_signed;
	logic [63:0]        mul_unsigned;

	//////////////////////////////////////////////////////////////////////
	// arithmetic and compare

	assign add_result  = src1 + src2;
	assign sub_result  = src1 - src2;
	assign slt_result  = {31'b0, $signed(src1) < $signed(src2)};
	assign sltu_result = {31'b0, src1 < src2};

	// shifts by the low five bits only
	assign shamt      = src2[4:0];
	assign sll_result = src1 << shamt;
	assign srl_result = src1 >> shamt;
	assign sra_result = $signed(src1) >>> shamt;

	// full 64-bit products, high halves for mulh and mulhu
	assign mul_signed   = $signed(src1) * $signed(src2);
	assign mul_unsigned = {32'b0, src1} * {32'b0, src2};

	//////////////////////////////////////////////////////////////////////
	// result select

	// lui gets src2 already shifted by decode
	assign result = ({32{op[ALU_ADD]}}   & add_result)
		| ({32{op[ALU_SUB]}}   & sub_result)
		| ({32{op[ALU_SLT]}}   & slt_result)
		| ({32{op[ALU_SLTU]}}  & sltu_result)
		| ({32{op[ALU_AND]}}   & (src1 & src2))
		| ({32{op[ALU_NOR]}}   & ~(src1 | src2))
		| ({32{op[ALU_OR]}}    & (src1 | src2))
		| ({32{op[ALU_XOR]}}   & (src1 ^ src2))
		| ({32{op[ALU_ANDN]}}  & (src1 & ~src2))
		| ({32{op[ALU_ORN]}}   & (src1 | ~src2))
		| ({32{op[ALU_SLL]}}   & sll_result)
		| ({32{op[ALU_SRL]}}   & srl_result)
		| ({32{op[ALU_SRA]}}   & sra_result)
		| ({32{op[ALU_LUI]}}   & src2)
		| ({32{op[ALU_MUL]}}   & mul_unsigned[31:0])
		| ({32{op[ALU_MULH]}}  & mul_signed[63:32])
		| ({32{op[ALU_MULHU]}} & mul_unsigned[63:32])
		| ({32{op[ALU_SRC2]}}  & src2)
		| ({32{op[ALU_SRC1]}}  & src1);

endmodule

`default_nettype wire

/* exe/exe_stage.sv */
/*
 * execute stage, registers the decoded instruction and computes its ALU
 * result in one cycle; feeds pre-memory and the bypass unit
 */
`default_nettype none
`timescale 1ns/1ps

module exe_stage (
	input  wire                             clk,
	input  wire                             reset,
	input  wire pipe_bus_pkg::id_to_exe_t   id_to_exe,
	input  wire                             id_to_exe_valid,
	output logic                            exe_allow_in,
	output pipe_bus_pkg::exe_to_pmem_t      exe_to_pmem,
	output logic                            exe_to_pmem_valid,
	input  wire                             pmem_allow_in,
	output pipe_bus_pkg::stage_bypass_t     exe_bypass
);
	import cpu_types_pkg::*;
	import pipe_bus_pkg::*;

	id_to_exe_t exe_reg;
	logic       exe_valid;
	word_t      alu_result;

	//////////////////////////////////////////////////////////////////////
	// pipeline control

	// every op finishes in one cycle, so ready_go is always true
	assign exe_allow_in      = ~exe_valid | pmem_allow_in;
	assign exe_to_pmem_valid = exe_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			exe_valid <= 1'b0;
		else if (exe_allow_in)
			exe_valid <= id_to_exe_valid;
	end

	always_ff @(posedge clk)
	begin
		if (exe_allow_in)
			exe_reg <= id_to_exe;
	end

	//////////////////////////////////////////////////////////////////////
	// ALU

	alu u_alu (
		.op     (exe_reg.op),
		.src1   (exe_reg.src1),
		.src2   (exe_reg.src2),
		.result (alu_result)
	);

	//////////////////////////////////////////////////////////////////////
	// outgoing buses

	always_comb
	begin
		exe_to_pmem.pc          = exe_reg.pc;
		exe_to_pmem.result      = alu_result;
		exe_to_pmem.mem_en      = exe_reg.mem_en;
		exe_to_pmem.mem_we      = exe_reg.mem_we;
		exe_to_pmem.mem_size    = exe_reg.mem_size;
		exe_to_pmem.mem_signed  = exe_reg.mem_signed;
		exe_to_pmem.mem_wdata   = exe_reg.mem_wdata;
		exe_to_pmem.rf_we       = exe_reg.rf_we;
		exe_to_pmem.rf_from_mem = exe_reg.rf_from_mem;
		exe_to_pmem.rf_waddr    = exe_reg.rf_waddr;
		exe_to_pmem.ready_stage = exe_reg.ready_stage;
	end

	// only results marked ready in execute may be forwarded from here
	always_comb
	begin
		exe_bypass.valid        = exe_valid;
		exe_bypass.rf_we        = exe_reg.rf_we;
		exe_bypass.result_ready = exe_reg.ready_stage[RS_EXE];
		exe_bypass.rf_waddr     = exe_reg.rf_waddr;
		exe_bypass.result       = alu_result;
	end

endmodule

`default_nettype wire

/* source/pmem_stage.sv */
/*
 * pre-memory stage, holds the instruction from execute and issues the
 * data RAM request as it moves on to write-back
 */
`default_nettype none
`timescale 1ns/1ps

module pmem_stage (
	input  wire                             clk,
	input  wire                             reset,
	input  wire pipe_bus_pkg::exe_to_pmem_t exe_to_pmem,
	input  wire                             exe_to_pmem_valid,
	output logic                            pmem_allow_in,
	output pipe_bus_pkg::pmem_to_wb_t       pmem_to_wb,
	output logic                            pmem_to_wb_valid,
	input  wire                             wb_allow_in,
	output logic                            dram_en,
	output logic                            dram_we,
	output cpu_types_pkg::word_t            dram_addr,
	output logic [3:0]                      dram_wstrb,
	output cpu_types_pkg::word_t            dram_wdata,
	output pipe_bus_pkg::stage_bypass_t     pmem_bypass
);
	import cpu_types_pkg::*;
	import pipe_bus_pkg::*;

	exe_to_pmem_t pmem_reg;
	logic         pmem_valid;
	logic [1:0]   byte_offset;
	logic [3:0]   size_strb;
	word_t        size_wdata;

	//////////////////////////////////////////////////////////////////////
	// pipeline control

	assign pmem_allow_in    = ~pmem_valid | wb_allow_in;
	assign pmem_to_wb_valid = pmem_valid;

	always_ff @(posedge clk)
	begin
		if (reset)
			pmem_valid <= 1'b0;
		else if (pmem_allow_in)
			pmem_valid <= exe_to_pmem_valid;
	end

	always_ff @(posedge clk)
	begin
		if (pmem_allow_in)
			pmem_reg <= exe_to_pmem;
	end

	//////////////////////////////////////////////////////////////////////
	// data RAM request, only on the transfer to write-back

	assign byte_offset = pmem_reg.result[1:0];

	// strobe and data before moving to the byte lane
	always_comb
	begin
		case (pmem_reg.mem_size)
			MEM_BYTE:
			begin
				size_strb  = 4'b0001;
				size_wdata = {24'b0, pmem_reg.mem_wdata[7:0]};
			end
			MEM_HALF:
			begin
				size_strb  = 4'b0011;
				size_wdata = {16'b0, pmem_reg.mem_wdata[15:0]};
			end
			default:
			begin
				size_strb  = 4'b1111;
				size_wdata = pmem_reg.mem_wdata;
			end
		endcase
	end

	assign dram_en    = pmem_valid & wb_allow_in & pmem_reg.mem_en;
	assign dram_we    = dram_en & pmem_reg.mem_we;
	assign dram_addr  = {pmem_reg.result[31:2], 2'b00};
	assign dram_wstrb = dram_we ? (size_strb << byte_offset) : 4'b0000;
	assign dram_wdata = size_wdata << {byte_offset, 3'b000};

	//////////////////////////////////////////////////////////////////////
	// outgoing buses

	always_comb
	begin
		pmem_to_wb.pc          = pmem_reg.pc;
		pmem_to_wb.result      = pmem_reg.result;
		pmem_to_wb.byte_offset = byte_offset;
		pmem_to_wb.mem_size    = pmem_reg.mem_size;
		pmem_to_wb.mem_signed  = pmem_reg.mem_signed;
		pmem_to_wb.rf_we       = pmem_reg.rf_we;
		pmem_to_wb.rf_from_mem = pmem_reg.rf_from_mem;
		pmem_to_wb.rf_waddr    = pmem_reg.rf_waddr;
	end

	// anything ready by execute or pre-memory can be forwarded from here
	always_comb
	begin
		pmem_bypass.valid        = pmem_valid;
		pmem_bypass.rf_we        = pmem_reg.rf_we;
		pmem_bypass.result_ready = pmem_reg.ready_stage[RS_EXE]
			| pmem_reg.ready_stage[RS_PMEM];
		pmem_bypass.rf_waddr     = pmem_reg.rf_waddr;
		pmem_bypass.result       = pmem_reg.result;
	end

endmodule

`default_nettype wire

/* source/bypass_unit.sv */
/*
 * operand forwarding for decode; the youngest producer wins and decode
 * stalls while that producer's result is not yet ready
 */
`default_nettype none
`timescale 1ns/1ps

module bypass_unit #(
	parameter bit FORWARD_FROM_PMEM = 1'b1
) (
	input  wire cpu_types_pkg::reg_addr_t      rj,
	input  wire cpu_types_pkg::reg_addr_t      rk,
	input  wire cpu_types_pkg::word_t          rj_value,
	input  wire cpu_types_pkg::word_t          rk_value,
	input  wire pipe_bus_pkg::stage_bypass_t   exe_bypass,
	input  wire pipe_bus_pkg::stage_bypass_t   pmem_bypass,
	output cpu_types_pkg::word_t               fwd_rj_value,
	output cpu_types_pkg::word_t               fwd_rk_value,
	output logic                               id_stall
);
	import cpu_types_pkg::*;
	import pipe_bus_pkg::*;

	// stage holds a live write to this register, never r0
	function automatic logic hits(stage_bypass_t bp, reg_addr_t addr);
		return bp.valid && bp.rf_we && (bp.rf_waddr == addr) && (addr != '0);
	endfunction

	function automatic word_t forward(reg_addr_t addr, word_t value,
		stage_bypass_t exe_bp, stage_bypass_t pmem_bp);
		if (hits(exe_bp, addr) && exe_bp.result_ready)
			return exe_bp.result;
		if (FORWARD_FROM_PMEM && hits(pmem_bp, addr) && pmem_bp.result_ready)
			return pmem_bp.result;
		return value;
	endfunction

	// only the youngest matching producer decides
	function automatic logic must_stall(reg_addr_t addr,
		stage_bypass_t exe_bp, stage_bypass_t pmem_bp);
		if (hits(exe_bp, addr))
			return !exe_bp.result_ready;
		return hits(pmem_bp, addr) && (!pmem_bp.result_ready || !FORWARD_FROM_PMEM);
	endfunction

	assign fwd_rj_value = forward(rj, rj_value, exe_bypass, pmem_bypass);
	assign fwd_rk_value = forward(rk, rk_value, exe_bypass, pmem_bypass);

	assign id_stall = must_stall(rj, exe_bypass, pmem_bypass)
		| must_stall(rk, exe_bypass, pmem_bypass);

endmodule

`default_nettype wire

/* source/exe_subsystem.sv */
/*
 * execute end of the pipeline; joins execute, pre-memory and the bypass
 * unit between the decode side, the data RAM and write-back
 */
`default_nettype none
`timescale 1ns/1ps

module exe_subsystem #(
	parameter bit FORWARD_FROM_PMEM = 1'b1
) (
	input  wire                             clk,
	input  wire                             reset,
	input  wire pipe_bus_pkg::id_to_exe_t   id_to_exe,
	input  wire                             id_to_exe_valid,
	output logic                            exe_allow_in,
	output pipe_bus_pkg::pmem_to_wb_t       pmem_to_wb,
	output logic                            pmem_to_wb_valid,
	input  wire                             wb_allow_in,
	output logic                            dram_en,
	output logic                            dram_we,
	output cpu_types_pkg::word_t            dram_addr,
	output cpu_types_pkg::word_t            dram_wdata,
	output logic [3:0]                      dram_wstrb,
	input  wire cpu_types_pkg::reg_addr_t   rj,
	input  wire cpu_types_pkg::reg_addr_t   rk,
	input  wire cpu_types_pkg::word_t       rj_value,
	input  wire cpu_types_pkg::word_t       rk_value,
	output cpu_types_pkg::word_t            fwd_rj_value,
	output cpu_types_pkg::word_t            fwd_rk_value,
	output logic                            id_stall
);
	import pipe_bus_pkg::*;

	exe_to_pmem_t  exe_to_pmem;
	logic          exe_to_pmem_valid;
	logic          pmem_allow_in;
	stage_bypass_t exe_bypass;
	stage_bypass_t pmem_bypass;

	exe_stage u_exe_stage (
		.clk               (clk),
		.reset             (reset),
		.id_to_exe         (id_to_exe),
		.id_to_exe_valid   (id_to_exe_valid),
		.exe_allow_in      (exe_allow_in),
		.exe_to_pmem       (exe_to_pmem),
		.exe_to_pmem_valid (exe_to_pmem_valid),
		.pmem_allow_in     (pmem_allow_in),
		.exe_bypass        (exe_bypass)
	);

	pmem_stage u_pmem_stage (
		.clk               (clk),
		.reset             (reset),
		.exe_to_pmem       (exe_to_pmem),
		.exe_to_pmem_valid (exe_to_pmem_valid),
		.pmem_allow_in     (pmem_allow_in),
		.pmem_to_wb        (pmem_to_wb),
		.pmem_to_wb_valid  (pmem_to_wb_valid),
		.wb_allow_in       (wb_allow_in),
		.dram_en           (dram_en),
		.dram_we           (dram_we),
		.dram_addr         (dram_addr),
		.dram_wstrb        (dram_wstrb),
		.dram_wdata        (dram_wdata),
		.pmem_bypass       (pmem_bypass)
	);

	// decode side reads forwarded operands and the stall
	bypass_unit #(
		.FORWARD_FROM_PMEM (FORWARD_FROM_PMEM)
	) u_bypass_unit (
		.rj           (rj),
		.rk           (rk),
		.rj_value     (rj_value),
		.rk_value     (rk_value),
		.exe_bypass   (exe_bypass),
		.pmem_bypass  (pmem_bypass),
		.fwd_rj_value (fwd_rj_value),
		.fwd_rk_value (fwd_rk_value),
		.id_stall     (id_stall)
	);

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
/*
 * free-running testbench clock, 8 ns period
 */
`default_nettype none
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 8
) (
	output logic clk
);
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* tests/exe_subsystem_assertions.sv */
/*
 * concurrent checks on the write-back handshake and the data RAM request,
 * bound into the execute subsystem top level
 */
`default_nettype none
`timescale 1ns/1ps

module exe_subsystem_assertions (
	input wire                          clk,
	input wire                          reset,
	input wire pipe_bus_pkg::pmem_to_wb_t pmem_to_wb,
	input wire                          pmem_to_wb_valid,
	input wire                          wb_allow_in,
	input wire                          dram_en,
	input wire                          id_to_exe_valid,
	input wire                          exe_allow_in
);
	int fail_count = 0;

	// held instruction must not move while write-back stalls
	wb_hold: assert property (@(posedge clk) disable iff (reset)
		(pmem_to_wb_valid && !wb_allow_in) |=> (pmem_to_wb_valid && $stable(pmem_to_wb)))
	else
	begin
		$error("pmem_to_wb changed while write-back was stalled");
		fail_count++;
	end

	dram_on_transfer: assert property (@(posedge clk) disable iff (reset)
		dram_en |-> (pmem_to_wb_valid && wb_allow_in))
	else
	begin
		$error("dram_en raised outside a write-back transfer");
		fail_count++;
	end

	// an edge that loads no instruction leaves execute empty and open
	empty_allows: assert property (@(posedge clk) disable iff (reset)
		(exe_allow_in && !id_to_exe_valid) |=> exe_allow_in)
	else
	begin
		$error("exe_allow_in low while execute is empty");
		fail_count++;
	end

endmodule

bind exe_subsystem exe_subsystem_assertions u_assertions (
	.clk               (clk),
	.reset             (reset),
	.pmem_to_wb        (pmem_to_wb),
	.pmem_to_wb_valid  (pmem_to_wb_valid),
	.wb_allow_in       (wb_allow_in),
	.dram_en           (dram_en),
	.id_to_exe_valid   (id_to_exe_valid),
	.exe_allow_in      (exe_allow_in)
);

`default_nettype wire

/* tests/exe_subsystem_tb.sv */
/*
 * testbench for the execute end; plays decode, the data RAM and write-back,
 * and checks every write-back transfer and the bypass outputs against a model
 */
`default_nettype none
`timescale 1ns/1ps

module exe_subsystem_tb;
	import cpu_types_pkg::*;
	import pipe_bus_pkg::*;

	localparam int ISSUE_TIMEOUT = 100;
	localparam int DRAIN_TIMEOUT = 100;

	// what the model expects of one instruction in flight
	typedef struct packed {
		pmem_to_wb_t  wb;
		ready_stage_t ready_stage;
		logic         mem_en;
		logic         mem_we;
		word_t        addr;
		logic [3:0]   strb;
		word_t        wdata;
	} model_t;

	logic        clk;
	logic        reset;
	id_to_exe_t  id_to_exe;
	logic        id_to_exe_valid;
	logic        exe_allow_in;
	pmem_to_wb_t pmem_to_wb;
	logic        pmem_to_wb_valid;
	logic        wb_allow_in;
	logic        dram_en;
	logic        dram_we;
	word_t       dram_addr;
	word_t       dram_wdata;
	logic [3:0]  dram_wstrb;
	reg_addr_t   rj;
	reg_addr_t   rk;
	word_t       rj_value;
	word_t       rk_value;
	word_t       fwd_rj_value;
	word_t       fwd_rk_value;
	logic        id_stall;

	model_t      q[$];
	model_t      cur_expect;
	logic        exe_v;
	logic        pmem_v;
	logic        bp_mode;
	word_t       pc_next;
	int          errors = 0;
	int          issued = 0;
	int          retired = 0;
	int          n_stall = 0;
	int          n_override = 0;
	int          n_backpressure = 0;

	tb_clock u_clock (.clk(clk));

	exe_subsystem #(
		.FORWARD_FROM_PMEM (1'b1)
	) UUT (
		.clk              (clk),
		.reset            (reset),
		.id_to_exe        (id_to_exe),
		.id_to_exe_valid  (id_to_exe_valid),
		.exe_allow_in     (exe_allow_in),
		.pmem_to_wb       (pmem_to_wb),
		.pmem_to_wb_valid (pmem_to_wb_valid),
		.wb_allow_in      (wb_allow_in),
		.dram_en          (dram_en),
		.dram_we          (dram_we),
		.dram_addr        (dram_addr),
		.dram_wdata       (dram_wdata),
		.dram_wstrb       (dram_wstrb),
		.rj               (rj),
		.rk               (rk),
		.rj_value         (rj_value),
		.rk_value         (rk_value),
		.fwd_rj_value     (fwd_rj_value),
		.fwd_rk_value     (fwd_rk_value),
		.id_stall         (id_stall)
	);

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic word_t alu_ref(int op_idx, word_t a, word_t b);
		logic signed [63:0] sp;
		logic [63:0]        up;
		word_t              r;
		sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
		up = {32'b0, a} * {32'b0, b};
		case (op_idx)
			ALU_ADD:   r = a + b;
			ALU_SUB:   r = a - b;
			ALU_SLT:   r = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU:  r = {31'b0, a < b};
			ALU_AND:   r = a & b;
			ALU_NOR:   r = ~(a | b);
			ALU_OR:    r = a | b;
			ALU_XOR:   r = a ^ b;
			ALU_ANDN:  r = a & ~b;
			ALU_ORN:   r = a | ~b;
			ALU_SLL:   r = a << b[4:0];
			ALU_SRL:   r = a >> b[4:0];
			ALU_SRA:   r = $signed(a) >>> b[4:0];
			ALU_LUI:   r = b;
			ALU_MUL:   r = up[31:0];
			ALU_MULH:  r = sp[63:32];
			ALU_MULHU: r = up[63:32];
			ALU_SRC2:  r = b;
			ALU_SRC1:  r = a;
			default:   r = '0;
		endcase
		return r;
	endfunction

	function automatic model_t expect_of(id_to_exe_t ins, int op_idx);
		model_t     m;
		word_t      res;
		logic [1:0] off;
		res = alu_ref(op_idx, ins.src1, ins.src2);
		off = res[1:0];
		m = '0;
		m.wb.pc          = ins.pc;
		m.wb.result      = res;
		m.wb.byte_offset = off;
		m.wb.mem_size    = ins.mem_size;
		m.wb.mem_signed  = ins.mem_signed;
		m.wb.rf_we       = ins.rf_we;
		m.wb.rf_from_mem = ins.rf_from_mem;
		m.wb.rf_waddr    = ins.rf_waddr;
		m.ready_stage    = ins.ready_stage;
		m.mem_en         = ins.mem_en;
		m.mem_we         = ins.mem_we;
		m.addr           = {res[31:2], 2'b00};
		// store data in its byte lane with other lanes zero
		case (ins.mem_size)
			MEM_BYTE:
			begin
				m.strb  = 4'b0001 << off;
				m.wdata = word_t'(ins.mem_wdata[7:0]) << {off, 3'b000};
			end
			MEM_HALF:
			begin
				m.strb  = 4'b0011 << off;
				m.wdata = word_t'(ins.mem_wdata[15:0]) << {off, 3'b000};
			end
			default:
			begin
				m.strb  = 4'b1111;
				m.wdata = ins.mem_wdata;
			end
		endcase
		return m;
	endfunction

	// youngest producer in the model pipeline decides
	function automatic void operand_expect(reg_addr_t r, word_t v, output word_t fwd,
		output logic stall, output logic both);
		model_t e;
		model_t p;
		logic   he;
		logic   hp;
		e = '0;
		p = '0;
		if (pmem_v)
			p = q[0];
		if (exe_v)
			e = q[pmem_v ? 1 : 0];
		he = exe_v && e.wb.rf_we && (e.wb.rf_waddr == r) && (r != 5'd0);
		hp = pmem_v && p.wb.rf_we && (p.wb.rf_waddr == r) && (r != 5'd0);
		both = he && hp;
		fwd = v;
		stall = 1'b0;
		if (he)
		begin
			fwd = e.wb.result;
			stall = !e.ready_stage[RS_EXE];
		end
		else if (hp)
		begin
			fwd = p.wb.result;
			stall = !(p.ready_stage[RS_EXE] | p.ready_stage[RS_PMEM]);
		end
	endfunction

	//////////////////////////////////////////////////////////////////////
	// reporting

	task automatic report_mismatch(string name, logic [127:0] got, logic [127:0] exp);
		errors++;
		$display("** Error at %0d ns: %s = %0h, expected %0h", $time, name, got, exp);
	endtask

	task automatic finish_run();
		errors += UUT.u_assertions.fail_count;
		$display("%0d errors, %0d issued, %0d retired", errors, issued, retired);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	task automatic timeout(string what);
		errors++;
		$display("timeout: %s", what);
		finish_run();
	endtask

	//////////////////////////////////////////////////////////////////////
	// model update and compare at mid-cycle

	always @(negedge clk)
	begin : model_compare
		model_t exp;
		logic   pmem_ok;
		logic   exe_ok;
		word_t  fj;
		word_t  fk;
		logic   sj;
		logic   sk;
		logic   bj;
		logic   bk;
		if (reset)
		begin
			exe_v = 1'b0;
			pmem_v = 1'b0;
			q.delete();
		end
		else
		begin
			pmem_ok = !pmem_v || wb_allow_in;
			exe_ok = !exe_v || pmem_ok;
			if (exe_allow_in !== exe_ok)
				report_mismatch("exe_allow_in", 128'(exe_allow_in), 128'(exe_ok));
			if (pmem_to_wb_valid !== pmem_v)
				report_mismatch("pmem_to_wb_valid", 128'(pmem_to_wb_valid), 128'(pmem_v));
			if (!exe_ok)
				n_backpressure++;

			operand_expect(rj, rj_value, fj, sj, bj);
			operand_expect(rk, rk_value, fk, sk, bk);
			if (id_stall !== (sj | sk))
				report_mismatch("id_stall", 128'(id_stall), 128'(sj | sk));
			if (!sj && fwd_rj_value !== fj)
				report_mismatch("fwd_rj_value", 128'(fwd_rj_value), 128'(fj));
			if (!sk && fwd_rk_value !== fk)
				report_mismatch("fwd_rk_value", 128'(fwd_rk_value), 128'(fk));
			if (sj | sk)
				n_stall++;
			if ((bj && !sj) || (bk && !sk))
				n_override++;

			if (pmem_v && wb_allow_in)
			begin
				if (q.size() == 0)
				begin
					errors++;
					$display("write-back transfer at %0d ns with nothing in flight", $time);
				end
				else
				begin
					exp = q.pop_front();
					retired++;
					if (pmem_to_wb !== exp.wb)
						report_mismatch("pmem_to_wb", 128'(pmem_to_wb), 128'(exp.wb));
					if (dram_en !== exp.mem_en)
						report_mismatch("dram_en", 128'(dram_en), 128'(exp.mem_en));
					if (exp.mem_en && dram_we !== exp.mem_we)
						report_mismatch("dram_we", 128'(dram_we), 128'(exp.mem_we));
					if (exp.mem_en && dram_addr !== exp.addr)
						report_mismatch("dram_addr", 128'(dram_addr), 128'(exp.addr));
					if (exp.mem_en && exp.mem_we && dram_wstrb !== exp.strb)
						report_mismatch("dram_wstrb", 128'(dram_wstrb), 128'(exp.strb));
					if (exp.mem_en && exp.mem_we && dram_wdata !== exp.wdata)
						report_mismatch("dram_wdata", 128'(dram_wdata), 128'(exp.wdata));
				end
			end
			else if (dram_en !== 1'b0)
				report_mismatch("dram_en", 128'(dram_en), 128'(0));

			// state after the coming edge
			if (pmem_ok)
				pmem_v = exe_v;
			if (exe_ok)
			begin
				exe_v = id_to_exe_valid;
				if (id_to_exe_valid)
				begin
					q.push_back(cur_expect);
					issued++;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	// advance one cycle and change decode-side inputs just after the edge
	task automatic step();
		@(posedge clk);
		#1;
		if (bp_mode)
			wb_allow_in = ($urandom_range(9, 0) < 6);
		rj = reg_addr_t'($urandom_range(3, 0));
		rk = reg_addr_t'($urandom_range(3, 0));
		rj_value = $urandom;
		rk_value = $urandom;
	endtask

	task automatic issue(id_to_exe_t ins, int op_idx);
		logic accepted;
		int   waited;
		ins.pc = pc_next;
		pc_next = pc_next + 32'd4;
		id_to_exe = ins;
		cur_expect = expect_of(ins, op_idx);
		id_to_exe_valid = 1'b1;
		accepted = 1'b0;
		waited = 0;
		while (!accepted && waited < ISSUE_TIMEOUT)
		begin
			@(negedge clk);
			accepted = exe_allow_in;
			step();
			waited++;
		end
		id_to_exe_valid = 1'b0;
		if (!accepted)
			timeout("execute never accepted an instruction");
	endtask

	task automatic drain();
		int waited;
		bp_mode = 1'b0;
		wb_allow_in = 1'b1;
		waited = 0;
		while (q.size() != 0 && waited < DRAIN_TIMEOUT)
		begin
			step();
			waited++;
		end
		if (q.size() != 0)
			timeout("pipeline did not drain");
	endtask

	function automatic id_to_exe_t make_alu(int op_idx);
		id_to_exe_t ins;
		ins = '0;
		ins.src1 = $urandom;
		ins.src2 = $urandom;
		ins.op = alu_op_t'(1 << op_idx);
		ins.rf_we = ($urandom_range(1, 0) == 1);
		ins.rf_waddr = reg_addr_t'($urandom_range(3, 0));
		ins.ready_stage = ready_stage_t'(32'd1 << $urandom_range(2, 0));
		return ins;
	endfunction

	function automatic id_to_exe_t make_mem(int size, int off, logic store);
		id_to_exe_t ins;
		ins = '0;
		ins.src1 = $urandom & 32'hffff_fffc;
		ins.src2 = word_t'(off);
		ins.op = alu_op_t'(1 << ALU_ADD);
		ins.mem_en = 1'b1;
		ins.mem_we = store;
		ins.mem_size = mem_size_t'(size);
		ins.mem_signed = ($urandom_range(1, 0) == 1);
		ins.mem_wdata = $urandom;
		ins.rf_we = !store;
		ins.rf_from_mem = !store;
		ins.rf_waddr = reg_addr_t'($urandom_range(3, 1));
		ins.ready_stage = store ? ready_stage_t'(3'b001) : ready_stage_t'(3'b100);
		return ins;
	endfunction

	initial
	begin
		int op;
		void'($urandom(67224));
		reset = 1'b1;
		id_to_exe = '0;
		id_to_exe_valid = 1'b0;
		wb_allow_in = 1'b1;
		rj = '0;
		rk = '0;
		rj_value = '0;
		rk_value = '0;
		cur_expect = '0;
		bp_mode = 1'b0;
		pc_next = 32'h1c00_0000;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		@(negedge clk);
		if (pmem_to_wb_valid !== 1'b0)
			report_mismatch("pmem_to_wb_valid", 128'(pmem_to_wb_valid), 128'(0));
		if (dram_en !== 1'b0)
			report_mismatch("dram_en", 128'(dram_en), 128'(0));
		if (exe_allow_in !== 1'b1)
			report_mismatch("exe_allow_in", 128'(exe_allow_in), 128'(1));
		if (id_stall !== 1'b0)
			report_mismatch("id_stall", 128'(id_stall), 128'(0));
		step();

		// every op back to back
		for (int i = 0; i < ALU_OPS; i++)
			repeat (8) issue(make_alu(i), i);

		// write-back stalls at random
		bp_mode = 1'b1;
		repeat (200)
		begin
			op = int'($urandom_range(ALU_OPS - 1, 0));
			if ($urandom_range(3, 0) != 0)
				issue(make_alu(op), op);
			else
				step();
		end
		drain();

		// stores and loads of each size at each aligned offset
		for (int s = 0; s < 3; s++)
		begin
			for (int off = 0; off < 4; off += (1 << s))
			begin
				issue(make_mem(s, off, 1'b1), ALU_ADD);
				issue(make_mem(s, off, 1'b0), ALU_ADD);
			end
		end
		drain();

		if (issued != retired)
		begin
			errors++;
			$display("%0d instructions issued but %0d retired", issued, retired);
		end
		if (n_stall == 0)
		begin
			errors++;
			$display("decode stall was never exercised");
		end
		if (n_override == 0)
		begin
			errors++;
			$display("execute never overrode a pre-memory producer");
		end
		if (n_backpressure == 0)
		begin
			errors++;
			$display("exe_allow_in never fell under back-pressure");
		end
		finish_run();
	end

endmodule

`default_nettype wire

/* tb.f */
common/cpu_types_pkg.sv
common/pipe_bus_pkg.sv
exe/alu.sv
exe/exe_stage.sv
source/pmem_stage.sv
source/bypass_unit.sv
source/exe_subsystem.sv
tests/tb_clock.sv
tests/exe_subsystem_assertions.sv
tests/exe_subsystem_tb.sv

/* Makefile */
# Verilator build and run for the execute subsystem testbench

VERILATOR ?= verilator
TOP       ?= exe_subsystem_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= all tests passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
